// ==== sim.f ====
verilog/mem_pkg.sv
verilog/sram_bank.sv
verilog/uart_rx.sv
verilog/ram_controller.sv
verilog/mem_subsystem.sv
sim/mem_subsystem_assertions.sv
sim/mem_subsystem_tb.sv

// ==== sim/mem_subsystem_assertions.sv ====
`timescale 1ns/1ps

module mem_subsystem_assertions (
	input logic               clk,
	input logic               rst_n,
	input mem_pkg::mem_req_t  req,
	input mem_pkg::bank_req_t bank1_req,
	input mem_pkg::bank_req_t bank2_req,
	input logic               read_ack
);
	import mem_pkg::*;

	int assert_fails = 0;

	// One target at a time
	one_bank_a: assert property (@(posedge clk) disable iff (!rst_n)
		!(bank1_req.need_to_work && bank2_req.need_to_work))
	else begin
		$error("need_to_work high for both banks");
		assert_fails++;
	end

	// Bank work only for a live request
	need_has_req_a: assert property (@(posedge clk) disable iff (!rst_n)
		(bank1_req.need_to_work || bank2_req.need_to_work) |-> (req.rd || req.wr))
	else begin
		$error("need_to_work high with no active request");
		assert_fails++;
	end

	// Ack only from a read of the data address
	ack_src_a: assert property (@(posedge clk) disable iff (!rst_n)
		read_ack |-> (req.rd && !req.wr && req.addr == UART_DATA_ADDR))
	else begin
		$error("read_ack without a read of the UART data address");
		assert_fails++;
	end

endmodule

bind ram_controller mem_subsystem_assertions u_assertions (.*);

// ==== sim/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb;
	import mem_pkg::*;

	// Sampling edge plus three edges to done
	localparam int BANK_EDGES     = 4;
	localparam int POLL_LIMIT     = 40;
	// Roughly 2000 cycles of traffic in all, so a wide margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        uart_rxd;
	logic        work_done;
	mem_req_t    req;
	mem_word_t   feedback;
	trace_t      trace;
	mem_word_t   bank_model [mem_addr_t];
	trace_t      trace_model;
	logic        ready_model;
	uart_byte_t  byte_model;
	string       cur_test;
	string       name_q [$];
	logic [95:0] exp_q [$];
	logic [95:0] got_q [$];
	int          checks_pushed = 0;
	int          checks_done = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycle_cnt = 0;

	always #20 clk = ~clk;

	mem_subsystem dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.uart_rxd  (uart_rxd),
		.work_done (work_done),
		.feedback  (feedback),
		.trace     (trace)
	);

	//////////////////////////////////////////////////
	// Reference model, applied once per access
	//////////////////////////////////////////////////
	function automatic mem_word_t ref_access(input mem_req_t r);
		mem_word_t result;
		if (r.addr == UART_STAT_ADDR) begin
			result = {14'h3fff, ready_model, 1'b1};
		end else if (r.addr == UART_DATA_ADDR) begin
			result = {8'h00, byte_model};
			ready_model = ready_model && !(r.rd && !r.wr);
		end else begin
			if (r.wr) begin
				bank_model[r.addr] = r.wdata;
			end
			result = bank_model[r.addr];
			if (r.addr[15]) begin
				trace_model.done_pc1  = r.pc;
				trace_model.done_act1 = r.act;
			end else begin
				trace_model.done_pc2  = r.pc;
				trace_model.done_act2 = r.act;
			end
		end
		return result;
	endfunction

	function automatic mem_addr_t skip_uart(input mem_addr_t a);
		if (a == UART_DATA_ADDR || a == UART_STAT_ADDR) begin
			a[4] = 1'b1;
		end
		return a;
	endfunction

	task automatic push_check(input string what, input logic [95:0] exp_v,
		input logic [95:0] got_v);
		name_q.push_back({cur_test, " ", what});
		exp_q.push_back(exp_v);
		got_q.push_back(got_v);
		checks_pushed++;
	endtask

	// One request, held until work_done, then dropped
	task automatic access(input logic rd, input logic wr, input mem_addr_t addr,
		input mem_word_t wdata, input bit chk, output mem_word_t data);
		mem_req_t r;
		int       edges;
		r       = '0;
		r.rd    = rd;
		r.wr    = wr;
		r.addr  = addr;
		r.wdata = wdata;
		r.pc    = 16'($urandom);
		r.act   = $urandom;
		edges   = 0;
		@(posedge clk);
		#1 req = r;
		@(negedge clk);
		while (!work_done) begin
			@(posedge clk);
			edges++;
			@(negedge clk);
		end
		data = feedback;
		@(posedge clk);
		#1 req = '0;
		if (chk) begin
			if (rd) begin
				push_check("read data", ref_access(r), data);
			end else begin
				void'(ref_access(r));
			end
			push_check("edges to done",
				(addr == UART_DATA_ADDR || addr == UART_STAT_ADDR) ? 0 : BANK_EDGES, edges);
			push_check("trace", trace_model, trace);
		end
	endtask

	// 8N1 frame, LSB first
	task automatic send_byte(input uart_byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			#1 uart_rxd = frame[i];
			repeat (UART_BIT_CLKS - 1) @(posedge clk);
		end
	endtask

	task automatic end_test();
		wait (checks_done == checks_pushed);
		tests_run++;
		if (test_errors == 0) begin
			$display("PASS  %s", cur_test);
		end else begin
			tests_failed++;
			$display("FAIL  %s with %0d errors", cur_test, test_errors);
		end
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////
	initial begin
		forever begin
			wait (checks_done < checks_pushed);
			if (exp_q[0] !== got_q[0]) begin
				$display("** Error %s: expected %0h, got %0h", name_q[0], exp_q[0], got_q[0]);
				test_errors++;
			end
			exp_q.delete(0);
			got_q.delete(0);
			name_q.delete(0);
			checks_done++;
		end
	end

	initial begin
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial begin
		mem_word_t  data;
		mem_word_t  w;
		mem_addr_t  a;
		mem_addr_t  addrs [$];
		uart_byte_t b;
		int         polls;
		void'($urandom(32'h93b4d909));
		rst_n       = 1'b0;
		req         = '0;
		uart_rxd    = 1'b1;
		ready_model = 1'b0;
		byte_model  = '0;
		trace_model = '1;
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;

		cur_test = "reset_trace";
		push_check("after reset", '1, trace);
		end_test();

		for (int bank = 1; bank <= 2; bank++) begin
			cur_test = (bank == 1) ? "bank1_rw" : "bank2_rw";
			addrs.delete();
			for (int i = 0; i < 40; i++) begin
				a     = 16'($urandom);
				a[15] = (bank == 1);
				a     = skip_uart(a);
				addrs.push_back(a);
				access(1'b0, 1'b1, a, 16'($urandom), 1'b1, data);
			end
			foreach (addrs[i]) begin
				access(1'b1, 1'b0, addrs[i], '0, 1'b1, data);
			end
			end_test();
		end

		cur_test = "bank_isolation";
		for (int i = 0; i < 8; i++) begin
			a = skip_uart({1'b1, 15'($urandom)}) & 16'h7fff;
			w = 16'($urandom);
			access(1'b0, 1'b1, a, w, 1'b1, data);
			access(1'b0, 1'b1, a | 16'h8000, ~w, 1'b1, data);
			access(1'b1, 1'b0, a, '0, 1'b1, data);
			access(1'b1, 1'b0, a | 16'h8000, '0, 1'b1, data);
		end
		end_test();

		cur_test = "uart_rx";
		for (int i = 0; i < 6; i++) begin
			b = 8'($urandom);
			send_byte(b);
			ready_model = 1'b1;
			byte_model  = b;
			polls       = 0;
			data        = '0;
			while (!data[1] && polls < POLL_LIMIT) begin
				access(1'b1, 1'b0, UART_STAT_ADDR, '0, 1'b0, data);
				polls++;
			end
			if (!data[1]) begin
				$display("uart_rx: byte ready not seen after %0d status reads", POLL_LIMIT);
				test_errors++;
			end
			access(1'b1, 1'b0, UART_STAT_ADDR, '0, 1'b1, data);
			access(1'b1, 1'b0, UART_DATA_ADDR, '0, 1'b1, data);
			access(1'b1, 1'b0, UART_STAT_ADDR, '0, 1'b1, data);
			// Ignored write still completes at once
			access(1'b0, 1'b1, UART_DATA_ADDR, 16'($urandom), 1'b1, data);
		end
		end_test();

		cur_test = "trace";
		for (int i = 0; i < 12; i++) begin
			a = skip_uart(16'($urandom));
			access(1'b0, 1'b1, a, 16'($urandom), 1'b1, data);
		end
		end_test();

		$display("Tests: %0d run, %0d failed, %0d assertion failures",
			tests_run, tests_failed, dut.u_ctrl.u_assertions.assert_fails);
		if (tests_failed == 0 && dut.u_ctrl.u_assertions.assert_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////
	localparam int MEM_ADDR_BITS  = 16;
	localparam int MEM_WORD_BITS  = 16;
	localparam int REG_WORD_BITS  = 16;
	localparam int ACT_TAG_BITS   = 32;
	localparam int BANK_ADDR_BITS = 15;
	localparam int UART_BYTE_BITS = 8;
	localparam int BANK_WORDS     = 2 ** BANK_ADDR_BITS;

	typedef logic [MEM_ADDR_BITS-1:0]  mem_addr_t;
	typedef logic [MEM_WORD_BITS-1:0]  mem_word_t;
	typedef logic [REG_WORD_BITS-1:0]  reg_word_t;
	typedef logic [ACT_TAG_BITS-1:0]   act_tag_t;
	typedef logic [BANK_ADDR_BITS-1:0] bank_addr_t;
	typedef logic [UART_BYTE_BITS-1:0] uart_byte_t;

	//////////////////////////////////////////////////
	// Address map and timing
	//////////////////////////////////////////////////
	localparam mem_addr_t UART_DATA_ADDR = 16'hBF00;
	localparam mem_addr_t UART_STAT_ADDR = 16'hBF01;

	localparam int BANK_WAIT_CYCLES = 2;
	localparam int UART_BIT_CLKS    = 8;
	localparam int BANK_CNT_BITS    = $clog2(BANK_WAIT_CYCLES + 1);
	localparam int UART_CNT_BITS    = $clog2(UART_BIT_CLKS);

	//////////////////////////////////////////////////
	// Bundles
	//////////////////////////////////////////////////
	typedef struct packed {
		logic      rd;
		logic      wr;
		mem_addr_t addr;
		mem_word_t wdata;
		reg_word_t pc;
		act_tag_t  act;
	} mem_req_t;

	typedef struct packed {
		logic       need_to_work;
		logic       wr;
		bank_addr_t addr;
		mem_word_t  wdata;
	} bank_req_t;

	typedef struct packed {
		logic      work_done;
		mem_word_t feedback;
	} bank_rsp_t;

	typedef struct packed {
		reg_word_t done_pc1;
		reg_word_t done_pc2;
		act_tag_t  done_act1;
		act_tag_t  done_act2;
	} trace_t;

	typedef enum logic [1:0] {
		BANK_IDLE,
		BANK_WAIT,
		BANK_DONE
	} bank_state_t;

endpackage

// ==== verilog/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
	input  logic               clk,
	input  logic               rst_n,
	input  mem_pkg::mem_req_t  req,
	input  logic               uart_rxd,
	output logic               work_done,
	output mem_pkg::mem_word_t feedback,
	output mem_pkg::trace_t    trace
);
	import mem_pkg::*;

	bank_req_t  bank1_req;
	bank_req_t  bank2_req;
	bank_rsp_t  bank1_rsp;
	bank_rsp_t  bank2_rsp;
	uart_byte_t rx_byte;
	logic       rx_ready;
	logic       read_ack;

	//////////////////////////////////////////////////
	// Controller
	//////////////////////////////////////////////////
	ram_controller u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.bank1_req (bank1_req),
		.bank2_req (bank2_req),
		.bank1_rsp (bank1_rsp),
		.bank2_rsp (bank2_rsp),
		.rx_byte   (rx_byte),
		.rx_ready  (rx_ready),
		.read_ack  (read_ack),
		.work_done (work_done),
		.feedback  (feedback),
		.trace     (trace)
	);

	//////////////////////////////////////////////////
	// Targets
	//////////////////////////////////////////////////
	// Bank 1 serves addr[15] set
	sram_bank u_bank1 (
		.clk      (clk),
		.rst_n    (rst_n),
		.bank_req (bank1_req),
		.bank_rsp (bank1_rsp)
	);

	sram_bank u_bank2 (
		.clk      (clk),
		.rst_n    (rst_n),
		.bank_req (bank2_req),
		.bank_rsp (bank2_rsp)
	);

	uart_rx u_uart_rx (
		.clk      (clk),
		.rst_n    (rst_n),
		.uart_rxd (uart_rxd),
		.read_ack (read_ack),
		.rx_byte  (rx_byte),
		.rx_ready (rx_ready)
	);

endmodule

// ==== verilog/ram_controller.sv ====
`timescale 1ns/1ps

module ram_controller (
	input  logic                clk,
	input  logic                rst_n,
	input  mem_pkg::mem_req_t   req,
	output mem_pkg::bank_req_t  bank1_req,
	output mem_pkg::bank_req_t  bank2_req,
	input  mem_pkg::bank_rsp_t  bank1_rsp,
	input  mem_pkg::bank_rsp_t  bank2_rsp,
	input  mem_pkg::uart_byte_t rx_byte,
	input  logic                rx_ready,
	output logic                read_ack,
	output logic                work_done,
	output mem_pkg::mem_word_t  feedback,
	output mem_pkg::trace_t     trace
);
	import mem_pkg::*;

	logic      req_active;
	logic      sel_uart_data;
	logic      sel_uart_stat;
	logic      sel_uart;
	logic      sel_bank1;
	logic      sel_bank2;
	logic      bank1_complete;
	logic      bank2_complete;
	mem_word_t status_word;
	mem_word_t data_word;
	trace_t    trace_q;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////
	assign req_active    = req.rd | req.wr;
	assign sel_uart_data = (req.addr == UART_DATA_ADDR);
	assign sel_uart_stat = (req.addr == UART_STAT_ADDR);
	assign sel_uart      = sel_uart_data | sel_uart_stat;

	// UART addresses sit inside bank 1's range and win
	assign sel_bank1 = !sel_uart && req.addr[MEM_ADDR_BITS-1];
	assign sel_bank2 = !sel_uart && !req.addr[MEM_ADDR_BITS-1];

	// Bit 1 byte ready, bit 0 transmitter ready, rest ones
	assign status_word = {{(MEM_WORD_BITS-2){1'b1}}, rx_ready, 1'b1};
	assign data_word   = {{(MEM_WORD_BITS-UART_BYTE_BITS){1'b0}}, rx_byte};

	//////////////////////////////////////////////////
	// Target selection and completion
	//////////////////////////////////////////////////
	always_comb begin
		bank1_req.need_to_work = 1'b0;
		bank1_req.wr           = req.wr;
		bank1_req.addr         = req.addr[BANK_ADDR_BITS-1:0];
		bank1_req.wdata        = req.wdata;
		bank2_req.need_to_work = 1'b0;
		bank2_req.wr           = req.wr;
		bank2_req.addr         = req.addr[BANK_ADDR_BITS-1:0];
		bank2_req.wdata        = req.wdata;
		work_done              = 1'b1;
		feedback               = '0;

		if (req_active) begin
			if (sel_uart) begin
				// Receiver answers at once, writes are dropped
				feedback = sel_uart_stat ? status_word : data_word;
			end else if (sel_bank1) begin
				if (bank1_rsp.work_done) begin
					feedback = bank1_rsp.feedback;
				end else begin
					work_done              = 1'b0;
					bank1_req.need_to_work = 1'b1;
				end
			end else if (sel_bank2) begin
				if (bank2_rsp.work_done) begin
					feedback = bank2_rsp.feedback;
				end else begin
					work_done              = 1'b0;
					bank2_req.need_to_work = 1'b1;
				end
			end
		end
	end

	// Data read completes in this cycle, so rx_ready drops at the next edge
	assign read_ack = req.rd && !req.wr && sel_uart_data;

	//////////////////////////////////////////////////
	// Trace of last completed bank accesses
	//////////////////////////////////////////////////
	assign bank1_complete = req_active && sel_bank1 && bank1_rsp.work_done;
	assign bank2_complete = req_active && sel_bank2 && bank2_rsp.work_done;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			trace_q <= '1;
		end else begin
			if (bank1_complete) begin
				trace_q.done_pc1  <= req.pc;
				trace_q.done_act1 <= req.act;
			end
			if (bank2_complete) begin
				trace_q.done_pc2  <= req.pc;
				trace_q.done_act2 <= req.act;
			end
		end
	end

	assign trace = trace_q;

endmodule

// ==== verilog/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank (
	input  logic               clk,
	input  logic               rst_n,
	input  mem_pkg::bank_req_t bank_req,
	output mem_pkg::bank_rsp_t bank_rsp
);
	import mem_pkg::*;

	mem_word_t                mem [BANK_WORDS];
	bank_state_t              state;
	logic [BANK_CNT_BITS-1:0] wait_cnt;
	logic                     start;
	logic                     wait_last;

	// Access captured when the request is taken
	logic       op_wr;
	bank_addr_t op_addr;
	mem_word_t  op_wdata;
	mem_word_t  rdata;

	assign start     = (state == BANK_IDLE) && bank_req.need_to_work;
	assign wait_last = (state == BANK_WAIT) &&
		(wait_cnt == BANK_CNT_BITS'(BANK_WAIT_CYCLES));

	//////////////////////////////////////////////////
	// Wait-state FSM
	//////////////////////////////////////////////////
	// Done rises BANK_WAIT_CYCLES+1 edges after the start edge
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= BANK_IDLE;
			wait_cnt <= '0;
		end else begin
			case (state)
				BANK_IDLE: begin
					if (bank_req.need_to_work) begin
						state    <= BANK_WAIT;
						wait_cnt <= '0;
					end
				end
				BANK_WAIT: begin
					if (wait_last) begin
						state <= BANK_DONE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				BANK_DONE: begin
					state <= BANK_IDLE;
				end
				default: begin
					state <= BANK_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Storage
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (start) begin
			op_wr    <= bank_req.wr;
			op_addr  <= bank_req.addr;
			op_wdata <= bank_req.wdata;
		end
	end

	// Array and feedback updated on entry to done
	always_ff @(posedge clk) begin
		if (wait_last) begin
			if (op_wr) begin
				mem[op_addr] <= op_wdata;
				rdata        <= op_wdata;
			end else begin
				rdata <= mem[op_addr];
			end
		end
	end

	assign bank_rsp.work_done = (state == BANK_DONE);
	assign bank_rsp.feedback  = rdata;

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                uart_rxd,
	input  logic                read_ack,
	output mem_pkg::uart_byte_t rx_byte,
	output logic                rx_ready
);
	import mem_pkg::*;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t                state;
	logic [UART_CNT_BITS-1:0] clk_cnt;
	logic [2:0]               bit_cnt;
	logic                     rxd_meta;
	logic                     rxd_sync;
	logic                     bit_end;
	logic                     half_bit;
	logic                     frame_good;
	uart_byte_t               shift_q;

	// Two-flop synchronizer, idle line is high
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= uart_rxd;
			rxd_sync <= rxd_meta;
		end
	end

	assign half_bit   = (clk_cnt == UART_CNT_BITS'(UART_BIT_CLKS / 2 - 1));
	assign bit_end    = (clk_cnt == UART_CNT_BITS'(UART_BIT_CLKS - 1));
	assign frame_good = (state == RX_STOP) && bit_end && rxd_sync;

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= RX_IDLE;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rxd_sync) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// Recheck the start bit at its middle
					if (half_bit) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rxd_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= RX_STOP;
						end
					end
				end
				RX_STOP: begin
					// Bad stop bit drops the frame
					if (bit_end) begin
						state <= RX_IDLE;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end) begin
			shift_q <= {rxd_sync, shift_q[UART_BYTE_BITS-1:1]};
		end
		if (frame_good) begin
			rx_byte <= shift_q;
		end
	end

	// New frame beats the ack
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_ready <= 1'b0;
		end else if (frame_good) begin
			rx_ready <= 1'b1;
		end else if (read_ack) begin
			rx_ready <= 1'b0;
		end
	end

endmodule
